//--- test/rob_tests.txt
# Columns: put <tag> <addr> <data> <beats minus one> in hex, idle <cycles>, rate <ready percent>
# A test runs from its test line to its end line and drains before the next one
test single
rate 100
put 1 1000 abcd 3
end
test same_tag
put 2 2000 1111 2
put 2 2100 2222 0
put 2 2200 3333 7
put 2 2300 4444 1
end
test mixed
rate 60
put 3 3000 a001 1
put 4 4000 a002 5
put 3 3100 a003 0
put 5 fffc a004 7
put 4 4100 a005 2
idle 6
put 3 3200 a006 4
put 6 6000 a007 0
end
test full
rate 0
put 7 7000 b001 1
put 8 7100 b002 0
put 7 7200 b003 2
put 9 7300 b004 3
put a 7400 b005 0
put 8 7500 b006 1
put b 7600 b007 4
put c 7700 b008 0
idle 10
rate 100
put d 7800 b009 2
end
test random
rate 35
put e e000 c001 3
put f e100 c002 7
put e e200 c003 1
idle 4
rate 80
put 0 e300 c004 2
put f e400 c005 0
put e e500 c006 5
rate 25
put 0 e600 c007 6
end

//--- filelist.f
+incdir+hw
hw/rob_pkg.sv
hw/rob_slot_if.sv
hw/rob_slot_store.sv
hw/rob_age_timers.sv
hw/rob_delivery_fsm.sv
hw/rob_beat_gen.sv
hw/rob_top.sv
test/rob_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the reorder buffer testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module rob_tb -f filelist.f -o rob_sim

out=$(./obj_dir/rob_sim)
echo "$out"

if echo "$out" | grep -qx "sim passed"; then
    exit 0
else
    exit 1
fi

//--- test/rob_tb.sv
`timescale 1ns/1ns
`include "rob_consts.svh"

module rob_tb;

    // Packet as it entered the DUT
    typedef struct packed {
        rob_pkg::tag_t   tag;
        rob_pkg::addr_t  addr;
        rob_pkg::data_t  data;
        rob_pkg::beats_t beats;
    } pkt_t;

    // One command of the test file
    typedef struct packed {
        logic [7:0]  op;      // p put, i idle, r rate, t test start, e test end
        logic [63:0] name;
        pkt_t        pkt;
        logic [31:0] num;
    } cmd_t;

    logic            i_clk;
    logic            i_rst_n;
    logic            i_in_valid;
    logic            o_in_ready;
    rob_pkg::tag_t   i_in_tag;
    rob_pkg::addr_t  i_in_addr;
    rob_pkg::data_t  i_in_data;
    rob_pkg::beats_t i_in_beats;
    logic            o_out_valid;
    logic            i_out_ready;
    rob_pkg::tag_t   o_out_tag;
    rob_pkg::addr_t  o_out_addr;
    rob_pkg::data_t  o_out_data;
    logic            o_out_last;

    cmd_t            cmds [$];
    pkt_t            exp_q [1 << `ROB_TAG_W][$];  // Scoreboard with one FIFO per tag
    pkt_t            req_pkt;                     // Next packet to offer
    logic            req_flag;
    logic            running;                     // Per cycle process active after reset
    int              ready_rate;                  // Percent of cycles with ready high
    int              accepted;
    int              completed;
    int              n_pending;                   // Accepted with the last beat not yet seen
    logic            in_fire;                     // Transfers due at the coming edge
    logic            out_fire_last;
    logic            in_pkt;                      // Inside a packet on the output
    pkt_t            cur_pkt;
    int              beat_idx;
    logic            held_valid;                  // Beat stalled at the last edge
    rob_pkg::tag_t   held_tag;
    rob_pkg::addr_t  held_addr;
    rob_pkg::data_t  held_data;
    logic            held_last;
    int              errors;
    int              cycles;
    int              cycle_limit;
    int              tests_ok;
    int              tests_bad;

    rob_top rob_top_inst (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_in_valid  (i_in_valid),
        .o_in_ready  (o_in_ready),
        .i_in_tag    (i_in_tag),
        .i_in_addr   (i_in_addr),
        .i_in_data   (i_in_data),
        .i_in_beats  (i_in_beats),
        .o_out_valid (o_out_valid),
        .i_out_ready (i_out_ready),
        .o_out_tag   (o_out_tag),
        .o_out_addr  (o_out_addr),
        .o_out_data  (o_out_data),
        .o_out_last  (o_out_last)
    );

    initial begin
        i_clk = 1'b0;
        forever begin
            #20 i_clk = ~i_clk;          // 40 ns period
        end
    end

    //////////////////////////////////////////////////
    // Helpers
    task automatic flag_error(input string msg);
        errors++;
        $display("** Error at %0t ns: %s", $time, msg);
    endtask

    task automatic finish_test(input logic [63:0] name, input int err_before);
        if (errors == err_before) begin
            tests_ok++;
            $display("Test %s: ok", name);
        end else begin
            tests_bad++;
            $display("Test %s: %0d errors", name, errors - err_before);
        end
    endtask

    // Parse the command file and size the timeout
    function automatic bit load_tests();
        int               fd;
        int               rc;
        int               total_beats;
        int               idle_cycles;
        bit               ok;
        logic [63:0]      word;
        logic [31:0]      v0;
        logic [31:0]      v1;
        logic [31:0]      v2;
        logic [31:0]      v3;
        logic [8*128-1:0] rest;
        cmd_t             c;
        total_beats = 0;
        idle_cycles = 0;
        ok          = 1'b1;
        fd = $fopen("test/rob_tests.txt", "r");
        if (fd == 0) begin
            ok = 1'b0;
        end else begin
            while ($fscanf(fd, "%s", word) == 1) begin
                c = '0;
                if (word == 64'("#")) begin
                    rc = $fgets(rest, fd);                 // Rest of a comment line
                end else if (word == 64'("put")) begin
                    rc = $fscanf(fd, "%h %h %h %h", v0, v1, v2, v3);
                    if (rc != 4)
                        ok = 1'b0;
                    c.op        = "p";
                    c.pkt.tag   = rob_pkg::tag_t'(v0);
                    c.pkt.addr  = rob_pkg::addr_t'(v1);
                    c.pkt.data  = rob_pkg::data_t'(v2);
                    c.pkt.beats = rob_pkg::beats_t'(v3);
                    total_beats += int'(c.pkt.beats) + 1;
                end else if (word == 64'("idle")) begin
                    rc = $fscanf(fd, "%d", v0);
                    c.op  = "i";
                    c.num = v0;
                    idle_cycles += int'(v0);
                end else if (word == 64'("rate")) begin
                    rc = $fscanf(fd, "%d", v0);
                    c.op  = "r";
                    c.num = v0;
                end else if (word == 64'("test")) begin
                    rc = $fscanf(fd, "%s", word);
                    c.op   = "t";
                    c.name = word;
                end else if (word == 64'("end")) begin
                    c.op = "e";
                end else begin
                    $display("Unknown command %s in the test file", word);
                    ok = 1'b0;
                end
                if (c.op != 8'd0)
                    cmds.push_back(c);
            end
            $fclose(fd);
        end
        cycle_limit = 10 * total_beats + idle_cycles + 200;
        return ok;
    endfunction

    //////////////////////////////////////////////////
    // Per cycle checks and drive on the falling edge
    task automatic check_hold();
        if (held_valid) begin
            if (!o_out_valid)
                flag_error("o_out_valid dropped while the beat was stalled");
            if ((o_out_tag != held_tag) || (o_out_addr != held_addr) ||
                (o_out_data != held_data) || (o_out_last != held_last))
                flag_error("beat outputs changed while the beat was stalled");
        end
    endtask

    task automatic check_in_ready();
        int outstanding;
        outstanding = accepted - completed;
        if ((outstanding == `ROB_DEPTH) && o_in_ready)
            flag_error("o_in_ready high with every slot holding a packet");
        if ((outstanding <= `ROB_DEPTH - 2) && !o_in_ready)
            flag_error($sformatf("o_in_ready low with %0d packets outstanding", outstanding));
    endtask

    task automatic drive_ready();
        i_out_ready = (int'($urandom % 100) < ready_rate);
        held_valid  = o_out_valid && !i_out_ready;   // Stall seen by the coming edge
        held_tag    = o_out_tag;
        held_addr   = o_out_addr;
        held_data   = o_out_data;
        held_last   = o_out_last;
    endtask

    task automatic check_beat();
        rob_pkg::addr_t exp_addr;
        logic           exp_last;
        out_fire_last = 1'b0;
        if (o_out_valid && i_out_ready) begin
            if (!in_pkt) begin
                if (exp_q[o_out_tag].size() == 0) begin
                    flag_error($sformatf("beat of tag %h with no packet of that tag due",
                        o_out_tag));
                end else begin
                    cur_pkt  = exp_q[o_out_tag].pop_front();   // Oldest of this tag
                    in_pkt   = 1'b1;
                    beat_idx = 0;
                end
            end
            if (in_pkt) begin
                exp_addr = cur_pkt.addr + rob_pkg::addr_t'(beat_idx);
                exp_last = (beat_idx == int'(cur_pkt.beats));
                if (o_out_tag != cur_pkt.tag)
                    flag_error($sformatf("tag %h inside a packet of tag %h",
                        o_out_tag, cur_pkt.tag));
                if (o_out_addr != exp_addr)
                    flag_error($sformatf("addr %h, expected %h", o_out_addr, exp_addr));
                if (o_out_data != cur_pkt.data)
                    flag_error($sformatf("data %h, expected %h", o_out_data, cur_pkt.data));
                if (o_out_last != exp_last)
                    flag_error($sformatf("last %b on beat %0d, expected %b",
                        o_out_last, beat_idx, exp_last));
                if (o_out_last) begin
                    in_pkt        = 1'b0;
                    n_pending--;
                    out_fire_last = 1'b1;
                end else begin
                    beat_idx++;
                end
            end
        end
    endtask

    task automatic drive_input();
        in_fire = 1'b0;
        if (req_flag) begin
            i_in_valid = 1'b1;
            i_in_tag   = req_pkt.tag;
            i_in_addr  = req_pkt.addr;
            i_in_data  = req_pkt.data;
            i_in_beats = req_pkt.beats;
            if (o_in_ready) begin
                in_fire = 1'b1;
                exp_q[req_pkt.tag].push_back(req_pkt);
                n_pending++;
                req_flag = 1'b0;                     // Sequence may offer the next one
            end
        end else begin
            i_in_valid = 1'b0;
        end
    endtask

    always @(negedge i_clk) begin
        if (running) begin
            cycles++;
            if (cycles > cycle_limit) begin
                $display("Timeout after %0d cycles with %0d packets still undelivered",
                    cycles, n_pending);
                $display("sim failed");
                $finish;
            end else begin
                if (in_fire)
                    accepted++;                      // Edge just passed took them
                if (out_fire_last)
                    completed++;
                check_hold();
                check_in_ready();
                drive_ready();
                check_beat();
                drive_input();
            end
        end
    end

    //////////////////////////////////////////////////
    // Command sequence
    initial begin
        cmd_t        c;
        logic [63:0] test_name;
        int          test_err;
        bit          ok;
        i_rst_n       = 1'b0;
        i_in_valid    = 1'b0;
        i_in_tag      = '0;
        i_in_addr     = '0;
        i_in_data     = '0;
        i_in_beats    = '0;
        i_out_ready   = 1'b0;
        req_pkt       = '0;
        req_flag      = 1'b0;
        running       = 1'b0;
        ready_rate    = 100;
        accepted      = 0;
        completed     = 0;
        n_pending     = 0;
        in_fire       = 1'b0;
        out_fire_last = 1'b0;
        in_pkt        = 1'b0;
        beat_idx      = 0;
        held_valid    = 1'b0;
        errors        = 0;
        cycles        = 0;
        cycle_limit   = 200;
        tests_ok      = 0;
        tests_bad     = 0;
        test_name     = 64'("none");
        test_err      = 0;
        void'($urandom(64130));
        ok = load_tests();
        if (!ok) begin
            $display("Could not read the test file test/rob_tests.txt");
            $display("sim failed");
            $finish;
        end else begin
            repeat (2) @(negedge i_clk);
            i_rst_n  = 1'b1;
            test_err = errors;
            if (o_out_valid !== 1'b0)
                flag_error("o_out_valid not low after reset");
            if (o_in_ready !== 1'b1)
                flag_error("o_in_ready not high after reset");
            finish_test(64'("reset"), test_err);
            @(posedge i_clk);
            running = 1'b1;
            while (cmds.size() > 0) begin
                c = cmds.pop_front();
                case (c.op)
                    "t": begin
                        test_name = c.name;
                        test_err  = errors;
                    end
                    "p": begin
                        req_pkt  = c.pkt;
                        req_flag = 1'b1;
                        wait (!req_flag);             // Accepted by the DUT
                    end
                    "i": repeat (c.num) @(posedge i_clk);
                    "r": ready_rate = int'(c.num);
                    "e": begin
                        wait ((n_pending == 0) && !req_flag);   // Drain the buffer
                        finish_test(test_name, test_err);
                    end
                    default: begin
                    end
                endcase
            end
            $display("Tests: %0d ok, %0d with errors, %0d errors in total",
                tests_ok, tests_bad, errors);
            if (errors == 0) begin
                $display("sim passed");
            end else begin
                $display("sim failed");
            end
            $finish;
        end
    end

endmodule

//--- hw/rob_top.sv
`timescale 1ns/1ns

module rob_top (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_in_valid,
    output logic             o_in_ready,
    input  rob_pkg::tag_t    i_in_tag,
    input  rob_pkg::addr_t   i_in_addr,
    input  rob_pkg::data_t   i_in_data,
    input  rob_pkg::beats_t  i_in_beats,
    output logic             o_out_valid,
    input  logic             i_out_ready,
    output rob_pkg::tag_t    o_out_tag,
    output rob_pkg::addr_t   o_out_addr,
    output rob_pkg::data_t   o_out_data,
    output logic             o_out_last
);

    rob_slot_if slot_bus ();

    // Granted packet, store to beat generator
    rob_pkg::tag_t    w_sel_tag;
    rob_pkg::addr_t   w_sel_addr;
    rob_pkg::data_t   w_sel_data;
    rob_pkg::beats_t  w_sel_beats;
    logic             w_load;
    logic             w_last_taken;

    rob_slot_store rob_slot_store_inst (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_in_valid  (i_in_valid),
        .o_in_ready  (o_in_ready),
        .i_in_tag    (i_in_tag),
        .i_in_addr   (i_in_addr),
        .i_in_data   (i_in_data),
        .i_in_beats  (i_in_beats),
        .slot        (slot_bus.store),
        .o_sel_tag   (w_sel_tag),
        .o_sel_addr  (w_sel_addr),
        .o_sel_data  (w_sel_data),
        .o_sel_beats (w_sel_beats)
    );

    rob_age_timers rob_age_timers_inst (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .slot    (slot_bus.timers)
    );

    rob_delivery_fsm rob_delivery_fsm_inst (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .slot         (slot_bus.fsm),
        .o_load       (w_load),
        .i_last_taken (w_last_taken)
    );

    rob_beat_gen rob_beat_gen_inst (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_load       (w_load),
        .i_tag        (w_sel_tag),
        .i_addr       (w_sel_addr),
        .i_data       (w_sel_data),
        .i_beats      (w_sel_beats),
        .o_out_valid  (o_out_valid),
        .i_out_ready  (i_out_ready),
        .o_out_tag    (o_out_tag),
        .o_out_addr   (o_out_addr),
        .o_out_data   (o_out_data),
        .o_out_last   (o_out_last),
        .o_last_taken (w_last_taken)
    );

endmodule

//--- hw/rob_beat_gen.sv
`timescale 1ns/1ns

module rob_beat_gen (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_load,
    input  rob_pkg::tag_t    i_tag,
    input  rob_pkg::addr_t   i_addr,
    input  rob_pkg::data_t   i_data,
    input  rob_pkg::beats_t  i_beats,
    output logic             o_out_valid,
    input  logic             i_out_ready,
    output rob_pkg::tag_t    o_out_tag,
    output rob_pkg::addr_t   o_out_addr,
    output rob_pkg::data_t   o_out_data,
    output logic             o_out_last,
    output logic             o_last_taken
);

    rob_pkg::tag_t    r_tag;
    rob_pkg::addr_t   r_base;
    rob_pkg::data_t   r_data;
    rob_pkg::beats_t  r_beats;
    rob_pkg::beats_t  r_cnt;      // Current beat index
    logic             r_armed;    // Packet held, first beat next cycle
    logic             r_valid;
    logic             w_take;

    assign w_take = r_valid && i_out_ready;

    // Packet fields
    always_ff @(posedge i_clk) begin
        if (i_load) begin
            r_tag   <= i_tag;
            r_base  <= i_addr;
            r_data  <= i_data;
            r_beats <= i_beats;
        end
    end

    //////////////////////////////////////////////////
    // Beat counting and handshake
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_cnt   <= '0;
            r_armed <= 1'b0;
            r_valid <= 1'b0;
        end else begin
            if (i_load) begin
                r_cnt   <= '0;
                r_armed <= 1'b1;
            end else if (r_armed) begin
                r_armed <= 1'b0;
                r_valid <= 1'b1;              // First beat goes out
            end else if (w_take) begin
                if (o_out_last)
                    r_valid <= 1'b0;          // Packet done
                else
                    r_cnt <= r_cnt + 1'b1;
            end
        end
    end

    assign o_out_valid  = r_valid;
    assign o_out_tag    = r_tag;
    assign o_out_data   = r_data;
    assign o_out_addr   = r_base + rob_pkg::addr_t'(r_cnt);  // Base plus beat index
    assign o_out_last   = (r_cnt == r_beats);
    assign o_last_taken = w_take && o_out_last;

    //////////////////////////////////////////////////
    // Checks
    a_hold_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_out_valid && !i_out_ready) |=> (o_out_valid && $stable(o_out_tag) &&
            $stable(o_out_addr) && $stable(o_out_data) && $stable(o_out_last)));

    // FSM never loads over a packet still in flight
    a_load_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_load |-> (!o_out_valid && !r_armed));

endmodule

//--- hw/rob_delivery_fsm.sv
`timescale 1ns/1ns

module rob_delivery_fsm (
    input  logic     i_clk,
    input  logic     i_rst_n,
    rob_slot_if.fsm  slot,
    output logic     o_load,        // Beat generator takes the selected fields
    input  logic     i_last_taken   // Final beat handshaken
);

    rob_pkg::deliv_state_t r_state;
    rob_pkg::deliv_state_t w_next;
    rob_pkg::slot_idx_t    r_idx;    // Slot owned from grant to release

    //////////////////////////////////////////////////
    // Next state
    always_comb begin
        w_next = r_state;
        case (r_state)
            rob_pkg::IDLE: begin
                if (slot.pick_valid)
                    w_next = rob_pkg::LOAD;
            end
            rob_pkg::LOAD: begin
                w_next = rob_pkg::SEND;         // Single cycle strobe
            end
            rob_pkg::SEND: begin
                if (i_last_taken)
                    w_next = rob_pkg::RELEASE;
            end
            rob_pkg::RELEASE: begin
                w_next = rob_pkg::IDLE;
            end
            default: begin
                w_next = rob_pkg::IDLE;         // Recover from a bad encoding
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_state <= rob_pkg::IDLE;
            r_idx   <= '0;
        end else begin
            r_state <= w_next;
            if (slot.grant)
                r_idx <= slot.pick_idx;         // Hold for release
        end
    end

    //////////////////////////////////////////////////
    // Strobes
    assign slot.grant       = (r_state == rob_pkg::IDLE) && slot.pick_valid;
    assign slot.grant_idx   = slot.pick_idx;
    assign o_load           = (r_state == rob_pkg::LOAD);
    assign slot.release_en  = (r_state == rob_pkg::RELEASE);
    assign slot.release_idx = r_idx;

    //////////////////////////////////////////////////
    // Checks
    // Grant from IDLE and the packet is being loaded next cycle
    a_grant_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        slot.grant |-> (r_state == rob_pkg::IDLE) ##1 (r_state == rob_pkg::LOAD));

    // Beat generator only finishes a packet this FSM is sending
    a_last_in_send: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_last_taken |-> (r_state == rob_pkg::SEND));

endmodule

//--- hw/rob_age_timers.sv
`timescale 1ns/1ns
`include "rob_consts.svh"

module rob_age_timers (
    input  logic       i_clk,
    input  logic       i_rst_n,
    rob_slot_if.timers slot
);

    rob_pkg::age_t      r_age [`ROB_DEPTH];  // Cycles since allocation
    rob_pkg::age_t      w_best_age;
    rob_pkg::slot_idx_t w_best_idx;
    logic               w_found;

    //////////////////////////////////////////////////
    // Saturating counters
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                r_age[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                if (slot.alloc && (slot.alloc_idx == rob_pkg::slot_idx_t'(i)))
                    r_age[i] <= '0;                   // Fresh packet
                else if (r_age[i] != rob_pkg::age_t'(`ROB_AGE_MAX))
                    r_age[i] <= r_age[i] + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Oldest waiting slot
    // Strict compare keeps the lowest index on a tie
    always_comb begin
        w_found    = 1'b0;
        w_best_age = '0;
        w_best_idx = '0;
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            if (slot.wait_vec[i] && (!w_found || (r_age[i] > w_best_age))) begin
                w_found    = 1'b1;
                w_best_age = r_age[i];
                w_best_idx = rob_pkg::slot_idx_t'(i);
            end
        end
    end

    assign slot.pick_valid = w_found;
    assign slot.pick_idx   = w_best_idx;

    // Pick must name a slot the store still holds as WAITING
    a_pick_waiting: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        slot.pick_valid |-> slot.wait_vec[slot.pick_idx]);

endmodule

//--- hw/rob_slot_store.sv
`timescale 1ns/1ns
`include "rob_consts.svh"

module rob_slot_store (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_in_valid,
    output logic             o_in_ready,
    input  rob_pkg::tag_t    i_in_tag,
    input  rob_pkg::addr_t   i_in_addr,
    input  rob_pkg::data_t   i_in_data,
    input  rob_pkg::beats_t  i_in_beats,
    rob_slot_if.store        slot,
    output rob_pkg::tag_t    o_sel_tag,
    output rob_pkg::addr_t   o_sel_addr,
    output rob_pkg::data_t   o_sel_data,
    output rob_pkg::beats_t  o_sel_beats
);

    // Per slot storage
    rob_pkg::slot_state_t r_state [`ROB_DEPTH];
    rob_pkg::tag_t        r_tag   [`ROB_DEPTH];
    rob_pkg::addr_t       r_addr  [`ROB_DEPTH];
    rob_pkg::data_t       r_data  [`ROB_DEPTH];
    rob_pkg::beats_t      r_beats [`ROB_DEPTH];
    rob_pkg::slot_idx_t   r_link  [`ROB_DEPTH];  // Slot this one waits on
    rob_pkg::slot_vec_t   r_tail;                // Newest packet of its tag
    rob_pkg::slot_idx_t   r_sel_idx;             // Last granted slot

    rob_pkg::slot_vec_t   w_free_vec;
    rob_pkg::slot_vec_t   w_wait_vec;
    rob_pkg::slot_vec_t   w_active_vec;
    rob_pkg::slot_idx_t   w_free_idx;
    rob_pkg::slot_idx_t   w_hit_idx;
    logic                 w_hit;                 // Tag already in flight
    logic                 w_chain;               // New packet must block
    logic                 w_accept;

    //////////////////////////////////////////////////
    // State decode
    always_comb begin
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            w_free_vec[i]   = (r_state[i] == rob_pkg::FREE);
            w_wait_vec[i]   = (r_state[i] == rob_pkg::WAITING);
            w_active_vec[i] = (r_state[i] == rob_pkg::ACTIVE);
        end
    end

    // Lowest free slot, scanned downward so index 0 wins
    always_comb begin
        w_free_idx = '0;
        for (int i = `ROB_DEPTH - 1; i >= 0; i--) begin
            if (w_free_vec[i])
                w_free_idx = rob_pkg::slot_idx_t'(i);
        end
    end

    // Tail of the incoming tag's chain
    always_comb begin
        w_hit     = 1'b0;
        w_hit_idx = '0;
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            if (r_tail[i] && !w_free_vec[i] && (r_tag[i] == i_in_tag)) begin
                w_hit     = 1'b1;
                w_hit_idx = rob_pkg::slot_idx_t'(i);
            end
        end
    end

    assign o_in_ready = |w_free_vec;
    assign w_accept   = i_in_valid && o_in_ready;
    // Tail leaving this very edge has nobody left to wake the newcomer
    assign w_chain    = w_hit && !(slot.release_en && (slot.release_idx == w_hit_idx));

    assign slot.alloc     = w_accept;
    assign slot.alloc_idx = w_free_idx;
    assign slot.wait_vec  = w_wait_vec;

    //////////////////////////////////////////////////
    // Slot states and chain bookkeeping
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                r_state[i] <= rob_pkg::FREE;
            end
            r_tail    <= '0;
            r_sel_idx <= '0;
        end else begin
            if (slot.grant) begin
                r_state[slot.grant_idx] <= rob_pkg::ACTIVE;
                r_sel_idx               <= slot.grant_idx;  // Feeds the beat generator
            end
            if (slot.release_en) begin
                r_state[slot.release_idx] <= rob_pkg::FREE;
                r_tail[slot.release_idx]  <= 1'b0;
                // Successor of the finished packet may go
                for (int i = 0; i < `ROB_DEPTH; i++) begin
                    if ((r_state[i] == rob_pkg::BLOCKED) && (r_link[i] == slot.release_idx))
                        r_state[i] <= rob_pkg::WAITING;
                end
            end
            if (w_accept) begin
                r_state[w_free_idx] <= w_chain ? rob_pkg::BLOCKED : rob_pkg::WAITING;
                r_tail[w_free_idx]  <= 1'b1;      // Newest of its tag
                if (w_hit)
                    r_tail[w_hit_idx] <= 1'b0;    // Old tail hands over
            end
        end
    end

    // Packet fields, written on accept only
    always_ff @(posedge i_clk) begin
        if (w_accept) begin
            r_tag[w_free_idx]   <= i_in_tag;
            r_addr[w_free_idx]  <= i_in_addr;
            r_data[w_free_idx]  <= i_in_data;
            r_beats[w_free_idx] <= i_in_beats;
            r_link[w_free_idx]  <= w_hit_idx;
        end
    end

    assign o_sel_tag   = r_tag[r_sel_idx];
    assign o_sel_addr  = r_addr[r_sel_idx];
    assign o_sel_data  = r_data[r_sel_idx];
    assign o_sel_beats = r_beats[r_sel_idx];

    //////////////////////////////////////////////////
    // Checks
    a_no_accept_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (w_free_vec == '0) |-> !slot.alloc);

    // FSM may only free what it was granted
    a_release_active: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        slot.release_en |-> (r_state[slot.release_idx] == rob_pkg::ACTIVE));

    a_one_active: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $onehot0(w_active_vec));

endmodule

//--- hw/rob_slot_if.sv
`timescale 1ns/1ns

interface rob_slot_if;

    // Allocation, from the slot store
    logic                alloc;
    rob_pkg::slot_idx_t  alloc_idx;
    rob_pkg::slot_vec_t  wait_vec;     // Slots in WAITING

    // Oldest waiting slot, from the age timers
    logic                pick_valid;
    rob_pkg::slot_idx_t  pick_idx;

    // Ownership changes, from the delivery FSM
    logic                grant;
    rob_pkg::slot_idx_t  grant_idx;
    logic                release_en;   // Active slot goes back to FREE
    rob_pkg::slot_idx_t  release_idx;

    modport store  (output alloc, alloc_idx, wait_vec,
                    input  grant, grant_idx, release_en, release_idx);

    modport timers (input  alloc, alloc_idx, wait_vec,
                    output pick_valid, pick_idx);

    modport fsm    (input  pick_valid, pick_idx,
                    output grant, grant_idx, release_en, release_idx);

endinterface

//--- hw/rob_pkg.sv
`include "rob_consts.svh"

package rob_pkg;

    // Field widths with a meaning
    typedef logic [`ROB_TAG_W-1:0]   tag_t;
    typedef logic [`ROB_ADDR_W-1:0]  addr_t;
    typedef logic [`ROB_DATA_W-1:0]  data_t;
    typedef logic [`ROB_BEATS_W-1:0] beats_t;     // Beats minus one
    typedef logic [`ROB_AGE_W-1:0]   age_t;
    typedef logic [`ROB_IDX_W-1:0]   slot_idx_t;
    typedef logic [`ROB_DEPTH-1:0]   slot_vec_t;  // One bit per slot

    // Life of one slot
    typedef enum logic [3:0] {
        FREE    = 4'b0001,  // Empty, can take a packet
        BLOCKED = 4'b0010,  // Waits behind an older packet of its tag
        WAITING = 4'b0100,  // Eligible for delivery
        ACTIVE  = 4'b1000   // Being sent
    } slot_state_t;

    // Delivery sequencer
    typedef enum logic [3:0] {
        IDLE    = 4'b0001,
        LOAD    = 4'b0010,
        SEND    = 4'b0100,
        RELEASE = 4'b1000
    } deliv_state_t;

endpackage

//--- hw/rob_consts.svh
`ifndef ROB_CONSTS_SVH
`define ROB_CONSTS_SVH

////////////////////////////////////////////////
// Buffer geometry
`define ROB_DEPTH    8   // Slots in the buffer
`define ROB_IDX_W    3   // Bits to name a slot

////////////////////////////////////////////////
// Packet fields
`define ROB_TAG_W    4   // Ordering tag
`define ROB_ADDR_W   16  // Base and beat address
`define ROB_DATA_W   16  // Single data word
`define ROB_BEATS_W  3   // Beat count minus one

////////////////////////////////////////////////
// Arbitration age
`define ROB_AGE_W    4
`define ROB_AGE_MAX  15  // Counter saturates here

`endif
